// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_unified_cache
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
design/cache_pkg.sv
design/port_arbiter.sv
design/cache_core.sv
design/axi_burst_master.sv
design/unified_cache_top.sv
test/axi_mem_model.sv
test/tb_unified_cache.sv

// File: design/axi_burst_master.sv
`timescale 1ns/1ps

module axi_burst_master import cache_pkg::*;
(
    input  logic                   clk_in,
    input  logic                   reset_in,
    input  logic                   axi_start,
    input  logic                   txn_write,
    input  logic [addr_width-1:0]  txn_addr,
    input  logic [block_width-1:0] txn_wdata,
    output logic [block_width-1:0] txn_rdata,
    output logic                   txn_done,
    output logic [addr_width-1:0]  araddr,
    output logic [7:0]             arlen,
    output logic                   arvalid,
    input  logic                   arready,
    input  logic [word_width-1:0]  rdata,
    input  logic                   rlast,
    input  logic                   rvalid,
    output logic                   rready,
    output logic [addr_width-1:0]  awaddr,
    output logic [7:0]             awlen,
    output logic                   awvalid,
    input  logic                   awready,
    output logic [word_width-1:0]  wdata,
    output logic                   wlast,
    output logic                   wvalid,
    input  logic                   wready,
    input  logic                   bvalid,
    output logic                   bready
);

axi_state_e              state;
logic                    write_q;
logic [addr_width-1:0]   addr_q;
logic [block_width-1:0]  wbuf;
logic [offset_width-1:0] beat_cnt;
logic                    last_beat;

assign last_beat = (beat_cnt == offset_width'(words_per_block - 1));

assign araddr = addr_q;
assign awaddr = addr_q;
assign arlen  = 8'(words_per_block - 1);
assign awlen  = 8'(words_per_block - 1);

// lowest word of the buffer is the current beat
assign wdata = wbuf[word_width-1:0];
assign wlast = wvalid && last_beat;

always_ff @(posedge clk_in)
begin
    if (reset_in)
    begin
        state    <= ax_idle;
        arvalid  <= 1'b0;
        awvalid  <= 1'b0;
        wvalid   <= 1'b0;
        rready   <= 1'b0;
        bready   <= 1'b0;
        txn_done <= 1'b0;
    end
    else
    begin
        txn_done <= 1'b0;
        case (state)
            ax_idle:
            begin
                if (axi_start)
                begin
                    write_q  <= txn_write;
                    addr_q   <= txn_addr;
                    wbuf     <= txn_wdata;
                    beat_cnt <= '0;
                    if (txn_write)
                        awvalid <= 1'b1;
                    else
                        arvalid <= 1'b1;
                    state <= ax_addr;
                end
            end
            ax_addr:
            begin
                if (write_q && awready)
                begin
                    awvalid <= 1'b0;
                    wvalid  <= 1'b1;
                    state   <= ax_data;
                end
                else if (!write_q && arready)
                begin
                    arvalid <= 1'b0;
                    rready  <= 1'b1;
                    state   <= ax_data;
                end
            end
            ax_data:
            begin
                if (write_q)
                begin
                    if (wready)
                    begin
                        wbuf     <= wbuf >> word_width;
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat)
                        begin
                            wvalid <= 1'b0;
                            bready <= 1'b1;
                            state  <= ax_resp;
                        end
                    end
                end
                else if (rvalid)
                begin
                    // first beat ends up in the lowest word
                    txn_rdata <= {rdata, txn_rdata[block_width-1:word_width]};
                    beat_cnt  <= beat_cnt + 1'b1;
                    if (last_beat)
                    begin
                        rready   <= 1'b0;
                        txn_done <= 1'b1;
                        state    <= ax_idle;
                    end
                end
            end
            ax_resp:
            begin
                if (bvalid)
                begin
                    bready   <= 1'b0;
                    txn_done <= 1'b1;
                    state    <= ax_idle;
                end
            end
            default:
                state <= ax_idle;
        endcase
    end
end

a_rlast_counted: assert property (@(posedge clk_in) disable iff (reset_in)
    (rvalid && rlast) |-> (state == ax_data && !write_q && last_beat));

endmodule

// File: design/cache_core.sv
`timescale 1ns/1ps

module cache_core import cache_pkg::*;
(
    input  logic                     clk_in,
    input  logic                     reset_in,
    input  logic                     core_req_valid,
    input  req_op_e                  core_req_op,
    input  logic [addr_width-1:0]    core_req_addr,
    input  logic [word_width-1:0]    core_req_wdata,
    input  logic [port_id_width-1:0] core_req_port,
    output logic                     core_busy,
    output logic                     resp_valid,
    output logic [port_id_width-1:0] resp_port,
    output logic [word_width-1:0]    resp_rdata,
    output logic                     mem_req_valid,
    output logic                     mem_req_write,
    output logic [addr_width-1:0]    mem_req_addr,
    output logic [block_width-1:0]   mem_req_wdata,
    input  logic                     mem_req_ack,
    input  logic [block_width-1:0]   fill_data
);

core_state_e            state;
logic [num_lines-1:0]   line_valid;
logic [num_lines-1:0]   line_dirty;
logic [tag_width-1:0]   tag_mem [num_lines];
logic [block_width-1:0] data_mem [num_lines];

req_op_e               op_q;
logic [addr_width-1:0] addr_q;
logic [word_width-1:0] wdata_q;

logic [tag_width-1:0]    addr_tag;
logic [index_width-1:0]  addr_index;
logic [offset_width-1:0] addr_offset;
logic                    hit;
logic [block_width-1:0]  base_block;
logic [block_width-1:0]  merged_block;
logic [word_width-1:0]   merged_word;

assign addr_tag    = addr_q[addr_width-1 -: tag_width];
assign addr_index  = addr_q[byte_offset_width + offset_width +: index_width];
assign addr_offset = addr_q[byte_offset_width +: offset_width];
assign hit         = line_valid[addr_index] && (tag_mem[addr_index] == addr_tag);

// during refill the incoming block stands in for the stored line
assign base_block = (state == st_refill) ? fill_data : data_mem[addr_index];

always_comb
begin
    merged_block = base_block;
    if (op_q == op_write)
        merged_block[addr_offset * word_width +: word_width] = wdata_q;
end

// read word, or the written word for a write
assign merged_word = merged_block[addr_offset * word_width +: word_width];

assign core_busy  = (state != st_idle);
assign resp_valid = (state == st_respond);

always_ff @(posedge clk_in)
begin
    if (reset_in)
    begin
        state         <= st_idle;
        line_valid    <= '0;
        line_dirty    <= '0;
        mem_req_valid <= 1'b0;
    end
    else
    begin
        case (state)
            st_idle:
            begin
                if (core_req_valid)
                begin
                    op_q      <= core_req_op;
                    addr_q    <= core_req_addr;
                    wdata_q   <= core_req_wdata;
                    resp_port <= core_req_port;
                    state     <= st_lookup;
                end
            end
            st_lookup:
            begin
                if (hit)
                begin
                    resp_rdata <= merged_word;
                    if (op_q == op_write)
                    begin
                        data_mem[addr_index]   <= merged_block;
                        line_dirty[addr_index] <= 1'b1;
                    end
                    state <= st_respond;
                end
                else if (line_valid[addr_index] && line_dirty[addr_index])
                begin
                    // victim goes out before the refill
                    mem_req_valid <= 1'b1;
                    mem_req_write <= 1'b1;
                    mem_req_addr  <= {tag_mem[addr_index], addr_index,
                                      {(offset_width + byte_offset_width){1'b0}}};
                    mem_req_wdata <= data_mem[addr_index];
                    state         <= st_writeback;
                end
                else
                    state <= st_refill;
            end
            st_writeback:
            begin
                if (mem_req_ack)
                begin
                    mem_req_valid <= 1'b0;
                    state         <= st_refill;
                end
            end
            st_refill:
            begin
                if (mem_req_ack)
                begin
                    mem_req_valid          <= 1'b0;
                    data_mem[addr_index]   <= merged_block;
                    tag_mem[addr_index]    <= addr_tag;
                    line_valid[addr_index] <= 1'b1;
                    line_dirty[addr_index] <= (op_q == op_write);
                    resp_rdata             <= merged_word;
                    state                  <= st_respond;
                end
                else if (!mem_req_valid)
                begin
                    mem_req_valid <= 1'b1;
                    mem_req_write <= 1'b0;
                    mem_req_addr  <= {addr_tag, addr_index,
                                      {(offset_width + byte_offset_width){1'b0}}};
                end
            end
            st_respond:
                state <= st_idle;
            default:
                state <= st_idle;
        endcase
    end
end

// the top only acks a request that is still held
a_ack_in_request: assert property (@(posedge clk_in) disable iff (reset_in)
    mem_req_ack |-> mem_req_valid);

endmodule

// File: design/cache_pkg.sv
package cache_pkg;

    // requester side
    localparam int num_ports     = 2;
    localparam int port_id_width = 1;

    // address and data sizes
    localparam int addr_width        = 32;
    localparam int word_width        = 32;
    localparam int words_per_block   = 4;
    localparam int block_width       = words_per_block * word_width;
    localparam int num_lines         = 8;
    localparam int index_width       = 3;
    localparam int offset_width      = 2;
    localparam int byte_offset_width = 2;
    localparam int tag_width         = addr_width - index_width - offset_width
                                       - byte_offset_width;

    // start of the cached memory window
    localparam logic [addr_width-1:0] mem_base_addr = 32'h1000_0000;

    typedef enum logic [0:0]
    {
        op_read,
        op_write
    } req_op_e;

    typedef enum logic [2:0]
    {
        st_idle,
        st_lookup,
        st_writeback,
        st_refill,
        st_respond
    } core_state_e;

    typedef enum logic [1:0]
    {
        ax_idle,
        ax_addr,
        ax_data,
        ax_resp
    } axi_state_e;

endpackage

// File: design/port_arbiter.sv
`timescale 1ns/1ps

module port_arbiter import cache_pkg::*;
(
    input  logic                                 clk_in,
    input  logic                                 reset_in,
    input  logic [num_ports-1:0]                 req_valid,
    input  req_op_e [num_ports-1:0]              req_op,
    input  logic [num_ports-1:0][addr_width-1:0] req_addr,
    input  logic [num_ports-1:0][word_width-1:0] req_wdata,
    input  logic                                 core_busy,
    output logic [num_ports-1:0]                 req_ack,
    output logic                                 core_req_valid,
    output req_op_e                              core_req_op,
    output logic [addr_width-1:0]                core_req_addr,
    output logic [word_width-1:0]                core_req_wdata,
    output logic [port_id_width-1:0]             core_req_port
);

logic [port_id_width-1:0] last_q;
logic [port_id_width-1:0] cand;
logic [port_id_width-1:0] pick;
logic                     found;

// search starts one past the last granted port
always_comb
begin
    pick  = last_q;
    found = 1'b0;
    cand  = last_q;
    for (int i = 1; i <= num_ports; i++)
    begin
        cand = port_id_width'((int'(last_q) + i) % num_ports);
        if (!found && req_valid[cand])
        begin
            pick  = cand;
            found = 1'b1;
        end
    end
end

assign core_req_valid = found && !core_busy;
assign core_req_op    = req_op[pick];
assign core_req_addr  = req_addr[pick];
assign core_req_wdata = req_wdata[pick];
assign core_req_port  = pick;

always_comb
begin
    req_ack       = '0;
    req_ack[pick] = core_req_valid;
end

always_ff @(posedge clk_in)
begin
    if (reset_in)
        last_q <= port_id_width'(num_ports - 1);
    else if (core_req_valid)
        last_q <= pick;
end

// at most one grant and never the last winner again while every port asks
a_ack_round_robin: assert property (@(posedge clk_in) disable iff (reset_in)
    $onehot0(req_ack) && !((&req_valid) && req_ack[last_q]));

endmodule

// File: design/unified_cache_top.sv
`timescale 1ns/1ps

module unified_cache_top import cache_pkg::*;
(
    input  logic                                 clk_in,
    input  logic                                 reset_in,
    input  logic [num_ports-1:0]                 req_valid,
    input  req_op_e [num_ports-1:0]              req_op,
    input  logic [num_ports-1:0][addr_width-1:0] req_addr,
    input  logic [num_ports-1:0][word_width-1:0] req_wdata,
    output logic [num_ports-1:0]                 req_ack,
    output logic [num_ports-1:0]                 resp_valid,
    output logic [num_ports-1:0][word_width-1:0] resp_rdata,
    output logic [addr_width-1:0]                araddr,
    output logic [7:0]                           arlen,
    output logic                                 arvalid,
    input  logic                                 arready,
    input  logic [word_width-1:0]                rdata,
    input  logic                                 rlast,
    input  logic                                 rvalid,
    output logic                                 rready,
    output logic [addr_width-1:0]                awaddr,
    output logic [7:0]                           awlen,
    output logic                                 awvalid,
    input  logic                                 awready,
    output logic [word_width-1:0]                wdata,
    output logic                                 wlast,
    output logic                                 wvalid,
    input  logic                                 wready,
    input  logic                                 bvalid,
    output logic                                 bready
);

logic                     core_req_valid;
req_op_e                  core_req_op;
logic [addr_width-1:0]    core_req_addr;
logic [word_width-1:0]    core_req_wdata;
logic [port_id_width-1:0] core_req_port;
logic                     core_busy;
logic                     core_resp_valid;
logic [port_id_width-1:0] core_resp_port;
logic [word_width-1:0]    core_resp_rdata;

logic                   mem_req_valid;
logic                   mem_req_write;
logic [addr_width-1:0]  mem_req_addr;
logic [block_width-1:0] mem_req_wdata;
logic                   mem_req_ack;
logic [block_width-1:0] fill_data;

logic                   mem_valid_d;
logic                   axi_start;
logic [block_width-1:0] txn_rdata;
logic                   txn_done;

// one start pulse per new held request, and the ack one cycle after done
always_ff @(posedge clk_in)
begin
    if (reset_in)
    begin
        mem_valid_d <= 1'b0;
        axi_start   <= 1'b0;
        mem_req_ack <= 1'b0;
    end
    else
    begin
        mem_valid_d <= mem_req_valid;
        axi_start   <= mem_req_valid && !mem_valid_d;
        mem_req_ack <= txn_done;
    end
end

// refill block is ready for the core alongside the ack
always_ff @(posedge clk_in)
begin
    if (txn_done && !mem_req_write)
        fill_data <= txn_rdata;
end

always_comb
begin
    for (int p = 0; p < num_ports; p++)
    begin
        resp_valid[p] = core_resp_valid && (core_resp_port == port_id_width'(p));
        resp_rdata[p] = core_resp_rdata;
    end
end

port_arbiter arb0
(
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .req_valid      (req_valid),
    .req_op         (req_op),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata),
    .core_busy      (core_busy),
    .req_ack        (req_ack),
    .core_req_valid (core_req_valid),
    .core_req_op    (core_req_op),
    .core_req_addr  (core_req_addr),
    .core_req_wdata (core_req_wdata),
    .core_req_port  (core_req_port)
);

cache_core core0
(
    .clk_in         (clk_in),
    .reset_in       (reset_in),
    .core_req_valid (core_req_valid),
    .core_req_op    (core_req_op),
    .core_req_addr  (core_req_addr),
    .core_req_wdata (core_req_wdata),
    .core_req_port  (core_req_port),
    .core_busy      (core_busy),
    .resp_valid     (core_resp_valid),
    .resp_port      (core_resp_port),
    .resp_rdata     (core_resp_rdata),
    .mem_req_valid  (mem_req_valid),
    .mem_req_write  (mem_req_write),
    .mem_req_addr   (mem_req_addr),
    .mem_req_wdata  (mem_req_wdata),
    .mem_req_ack    (mem_req_ack),
    .fill_data      (fill_data)
);

axi_burst_master axi0
(
    .clk_in    (clk_in),
    .reset_in  (reset_in),
    .axi_start (axi_start),
    .txn_write (mem_req_write),
    .txn_addr  (mem_req_addr),
    .txn_wdata (mem_req_wdata),
    .txn_rdata (txn_rdata),
    .txn_done  (txn_done),
    .araddr    (araddr),
    .arlen     (arlen),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rlast     (rlast),
    .rvalid    (rvalid),
    .rready    (rready),
    .awaddr    (awaddr),
    .awlen     (awlen),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wlast     (wlast),
    .wvalid    (wvalid),
    .wready    (wready),
    .bvalid    (bvalid),
    .bready    (bready)
);

endmodule

// File: test/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model import cache_pkg::*;
(
    input  logic                  clk_in,
    input  logic                  reset_in,
    input  logic [addr_width-1:0] araddr,
    input  logic [7:0]            arlen,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [word_width-1:0] rdata,
    output logic                  rlast,
    output logic                  rvalid,
    input  logic                  rready,
    input  logic [addr_width-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [word_width-1:0] wdata,
    input  logic                  wlast,
    input  logic                  wvalid,
    output logic                  wready,
    output logic                  bvalid,
    input  logic                  bready
);

localparam int mem_words = 256;

logic [word_width-1:0] mem [mem_words];
integer                stall_seed;
logic                  rd_busy;
logic                  wr_busy;
logic [7:0]            rd_base;
logic [7:0]            rd_cnt;
logic [7:0]            rd_len;
logic [7:0]            wr_base;
logic [7:0]            wr_cnt;

initial
begin
    stall_seed = 32'h5293;
    // every word starts as its own address with a marker
    for (int i = 0; i < mem_words; i++)
        mem[i] <= (mem_base_addr + 32'(i * 4)) ^ 32'hA5A5_0000;
end

assign rdata = mem[rd_base + rd_cnt];
assign rlast = rvalid && (rd_cnt == rd_len);

always @(posedge clk_in)
begin
    logic [31:0] r;
    r = $random(stall_seed);
    if (reset_in)
    begin
        arready <= 1'b0;
        rvalid  <= 1'b0;
        rd_busy <= 1'b0;
        awready <= 1'b0;
        wready  <= 1'b0;
        bvalid  <= 1'b0;
        wr_busy <= 1'b0;
    end
    else
    begin
        if (arvalid && arready)
        begin
            rd_busy <= 1'b1;
            rd_base <= araddr[9:2];
            rd_len  <= arlen;
            rd_cnt  <= 8'd0;
            arready <= 1'b0;
        end
        else
            arready <= !rd_busy && (r[1:0] != 2'b00);

        // read beats, each one stalled at random
        if (rd_busy)
        begin
            if (rvalid && rready)
            begin
                if (rd_cnt == rd_len)
                begin
                    rd_busy <= 1'b0;
                    rvalid  <= 1'b0;
                end
                else
                begin
                    rd_cnt <= rd_cnt + 8'd1;
                    rvalid <= (r[3:2] != 2'b00);
                end
            end
            else if (!rvalid)
                rvalid <= (r[3:2] != 2'b00);
        end

        if (awvalid && awready)
        begin
            wr_busy <= 1'b1;
            wr_base <= awaddr[9:2];
            wr_cnt  <= 8'd0;
            awready <= 1'b0;
        end
        else
            awready <= !wr_busy && !bvalid && (r[5:4] != 2'b00);

        if (wr_busy)
        begin
            if (wvalid && wready)
            begin
                mem[wr_base + wr_cnt] <= wdata;
                wr_cnt <= wr_cnt + 8'd1;
                if (wlast)
                begin
                    wr_busy <= 1'b0;
                    wready  <= 1'b0;
                    bvalid  <= 1'b1;
                end
                else
                    wready <= (r[7:6] != 2'b00);
            end
            else
                wready <= (r[7:6] != 2'b00);
        end

        if (bvalid && bready)
            bvalid <= 1'b0;
    end
end

endmodule

// File: test/tb_unified_cache.sv
`timescale 1ns/1ps

module tb_unified_cache import cache_pkg::*;
();

localparam int ops_per_port = 150;
localparam int sweep_ops    = 256;
localparam int directed_ops = 5;
localparam int total_ops    = num_ports * ops_per_port + sweep_ops + directed_ops;
localparam int max_cycles   = total_ops * 40 + 500;

logic                                 clk_in = 1'b0;
logic                                 reset_in;
logic [num_ports-1:0]                 req_valid;
req_op_e [num_ports-1:0]              req_op;
logic [num_ports-1:0][addr_width-1:0] req_addr;
logic [num_ports-1:0][word_width-1:0] req_wdata;
logic [num_ports-1:0]                 req_ack;
logic [num_ports-1:0]                 resp_valid;
logic [num_ports-1:0][word_width-1:0] resp_rdata;

logic [addr_width-1:0] araddr;
logic [7:0]            arlen;
logic                  arvalid;
logic                  arready;
logic [word_width-1:0] rdata;
logic                  rlast;
logic                  rvalid;
logic                  rready;
logic [addr_width-1:0] awaddr;
logic [7:0]            awlen;
logic                  awvalid;
logic                  awready;
logic [word_width-1:0] wdata;
logic                  wlast;
logic                  wvalid;
logic                  wready;
logic                  bvalid;
logic                  bready;

// command word is {op, addr, wdata}
logic [64:0]           cmd_q [num_ports][$];
logic [word_width-1:0] exp_q [num_ports][$];
logic [word_width-1:0] shadow [256];

integer seed;
string  cur_test;
int     cycle_count = 0;
int     check_errors = 0;
int     fair_errors = 0;
int     compl_errors = 0;
int     tests_run = 0;
int     tests_failed = 0;
int     wait_grants [num_ports];
int     ack_count [num_ports];
int     resp_count [num_ports];

always #10 clk_in = ~clk_in;

unified_cache_top dut0
(
    .clk_in     (clk_in),
    .reset_in   (reset_in),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_ack    (req_ack),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .araddr     (araddr),
    .arlen      (arlen),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rlast      (rlast),
    .rvalid     (rvalid),
    .rready     (rready),
    .awaddr     (awaddr),
    .awlen      (awlen),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wlast      (wlast),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready)
);

axi_mem_model mem0
(
    .clk_in   (clk_in),
    .reset_in (reset_in),
    .araddr   (araddr),
    .arlen    (arlen),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rlast    (rlast),
    .rvalid   (rvalid),
    .rready   (rready),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wlast    (wlast),
    .wvalid   (wvalid),
    .wready   (wready),
    .bvalid   (bvalid),
    .bready   (bready)
);

// requester drivers, response checks and the shadow model
always @(posedge clk_in)
begin
    logic [64:0]           cmd;
    logic [7:0]            widx;
    logic [word_width-1:0] expected;
    if (!reset_in)
    begin
        for (int p = 0; p < num_ports; p++)
        begin
            if (req_ack[p])
                wait_grants[p] = 0;
            else if (req_valid[p] && (req_ack != '0))
            begin
                wait_grants[p] = wait_grants[p] + 1;
                if (wait_grants[p] > 1)
                begin
                    $display("port %0d waited through %0d grants of the other port",
                             p, wait_grants[p]);
                    fair_errors++;
                end
            end

            if (resp_valid[p])
            begin
                resp_count[p]++;
                if (exp_q[p].size() == 0)
                begin
                    $display("port %0d got a response with no request outstanding", p);
                    compl_errors++;
                end
                else
                begin
                    expected = exp_q[p].pop_front();
                    if (resp_rdata[p] !== expected)
                    begin
                        $display("FAILED %s port %0d: expected %h, actual %h",
                                 cur_test, p, expected, resp_rdata[p]);
                        check_errors++;
                    end
                end
            end

            // requests complete in grant order, so the shadow is updated here
            if (req_valid[p] && req_ack[p])
            begin
                ack_count[p]++;
                widx = req_addr[p][9:2];
                if (req_op[p] == op_write)
                begin
                    shadow[widx] = req_wdata[p];
                    exp_q[p].push_back(req_wdata[p]);
                end
                else
                    exp_q[p].push_back(shadow[widx]);
            end

            if (!req_valid[p] || req_ack[p])
            begin
                if (cmd_q[p].size() > 0)
                begin
                    cmd = cmd_q[p].pop_front();
                    req_valid[p] <= 1'b1;
                    req_op[p]    <= req_op_e'(cmd[64]);
                    req_addr[p]  <= cmd[63:32];
                    req_wdata[p] <= cmd[31:0];
                end
                else
                    req_valid[p] <= 1'b0;
            end
        end
    end
end

// burst shape at each address handshake
always @(posedge clk_in)
begin
    if (!reset_in)
    begin
        if (arvalid && arready)
            check_burst("read", araddr, arlen);
        if (awvalid && awready)
            check_burst("write", awaddr, awlen);
    end
end

always @(posedge clk_in)
begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles)
    begin
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end
end

task automatic queue_op(int port, req_op_e op, logic [31:0] addr, logic [31:0] data);
    cmd_q[port].push_back({op, addr, data});
endtask

task automatic wait_idle();
    do
        @(negedge clk_in);
    while (cmd_q[0].size() != 0 || cmd_q[1].size() != 0 || req_valid != '0
           || exp_q[0].size() != 0 || exp_q[1].size() != 0);
endtask

task automatic run_one(int port, req_op_e op, logic [31:0] addr, logic [31:0] data);
    queue_op(port, op, addr, data);
    wait_idle();
endtask

task automatic expect_low(string sig, logic [31:0] actual);
    if (actual != 32'd0)
    begin
        $display("FAILED %s %s: expected 0, actual %0h", cur_test, sig, actual);
        check_errors++;
    end
endtask

// one block of words_per_block beats inside the 1 KB window
task automatic check_burst(string chan, logic [31:0] addr, logic [7:0] len);
    if (int'(len) != words_per_block - 1)
    begin
        $display("FAILED %s %s burst length: expected %0d, actual %0d",
                 cur_test, chan, words_per_block - 1, len);
        check_errors++;
    end
    if (addr[3:0] != 4'd0 || addr < mem_base_addr || addr >= mem_base_addr + 32'h400)
    begin
        $display("%s burst address %h is not a block inside the memory window",
                 chan, addr);
        check_errors++;
    end
endtask

task automatic report_test(string name, int fails);
    tests_run++;
    if (fails == 0)
        $display("%-16s ok", name);
    else
    begin
        tests_failed++;
        $display("%-16s FAIL, %0d bad checks", name, fails);
    end
endtask

initial
begin
    int          fails_before;
    logic [31:0] rnd;
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    seed = 32'h5293;
    reset_in  <= 1'b1;
    req_valid <= '0;
    for (int p = 0; p < num_ports; p++)
    begin
        req_op[p]      <= op_read;
        req_addr[p]    <= '0;
        req_wdata[p]   <= '0;
        wait_grants[p] = 0;
        ack_count[p]   = 0;
        resp_count[p]  = 0;
    end
    for (int i = 0; i < 256; i++)
        shadow[i] = (mem_base_addr + 32'(i * 4)) ^ 32'hA5A5_0000;
    repeat (5) @(posedge clk_in);
    reset_in <= 1'b0;

    cur_test = "reset_idle";
    fails_before = check_errors;
    repeat (3)
    begin
        @(negedge clk_in);
        expect_low("req_ack", 32'(req_ack));
        expect_low("resp_valid", 32'(resp_valid));
        expect_low("arvalid", 32'(arvalid));
        expect_low("awvalid", 32'(awvalid));
        expect_low("wvalid", 32'(wvalid));
        expect_low("wlast", 32'(wlast));
        expect_low("rready", 32'(rready));
        expect_low("bready", 32'(bready));
    end
    report_test(cur_test, check_errors - fails_before);

    // same line index, other tag, so each access evicts the other
    cur_test = "write_then_read";
    fails_before = check_errors;
    addr_a = mem_base_addr + 32'h40;
    addr_b = addr_a + 32'h80;
    run_one(0, op_write, addr_a, 32'h1234_5678);
    run_one(1, op_read, addr_a, '0);
    run_one(0, op_write, addr_b, 32'h0bad_cafe);
    run_one(1, op_read, addr_a, '0);
    run_one(0, op_read, addr_b, '0);
    report_test(cur_test, check_errors - fails_before);

    cur_test = "random_two_port";
    fails_before = check_errors;
    for (int i = 0; i < ops_per_port; i++)
    begin
        for (int p = 0; p < num_ports; p++)
        begin
            rnd = $random(seed);
            queue_op(p, rnd[31] ? op_write : op_read,
                     mem_base_addr + {22'd0, rnd[7:0], 2'b00}, $random(seed));
        end
    end
    wait_idle();
    report_test(cur_test, check_errors - fails_before);

    cur_test = "final_sweep";
    fails_before = check_errors;
    for (int w = 0; w < sweep_ops; w++)
        queue_op(0, op_read, mem_base_addr + 32'(w * 4), '0);
    wait_idle();
    report_test(cur_test, check_errors - fails_before);

    report_test("fairness", fair_errors);

    for (int p = 0; p < num_ports; p++)
    begin
        if (ack_count[p] != resp_count[p])
        begin
            $display("port %0d had %0d grants but %0d responses",
                     p, ack_count[p], resp_count[p]);
            compl_errors++;
        end
    end
    report_test("completion", compl_errors);

    $display("tests run %0d, tests failed %0d, bad checks %0d",
             tests_run, tests_failed, check_errors + fair_errors + compl_errors);
    if (check_errors + fair_errors + compl_errors == 0)
        $display("*** TEST PASSED ***");
    else
        $display("*** TEST FAILED ***");
    $finish;
end

endmodule
